/* dv/lsu_tb.sv */
`timescale 1ns/1ns

module lsu_tb;

	localparam int DONE_TIMEOUT = 200;
	localparam int BUSY_TIMEOUT = 20;

	typedef struct packed {
		lsu_pkg::mem_op_t op;
		lsu_pkg::addr_t addr;
		lsu_pkg::word_t data;
		lsu_pkg::word_t expected;
		logic [1:0] xfers;
	} step_t;

	logic clock;
	logic reset = 1'b1;
	logic req = 1'b0;
	lsu_pkg::mem_op_t op = lsu_pkg::OP_LW;
	lsu_pkg::addr_t addr = '0;
	lsu_pkg::word_t store_data = '0;
	logic busy;
	logic done;
	lsu_pkg::word_t load_data;
	logic arvalid;
	logic arready = 1'b0;
	lsu_pkg::addr_t araddr;
	logic rvalid = 1'b0;
	logic rready;
	lsu_pkg::beat_t rdata = '0;
	logic awvalid;
	logic awready = 1'b0;
	lsu_pkg::addr_t awaddr;
	logic wvalid;
	logic wready = 1'b0;
	lsu_pkg::beat_t bus_wdata;
	lsu_pkg::strb_t wstrb;
	logic bvalid = 1'b0;
	logic bready;

	// access under test, read by the responder
	lsu_pkg::mem_op_t cur_op = lsu_pkg::OP_LW;
	lsu_pkg::addr_t cur_addr = '0;
	lsu_pkg::word_t cur_data = '0;
	int ar_mark = 0;
	int aw_mark = 0;

	int ar_count = 0;
	int aw_count = 0;
	int done_count = 0;
	logic [7:0] mem [256];
	logic [4:0] r_block = '0;
	logic [4:0] w_block = '0;
	logic r_pending = 1'b0;
	logic b_pending = 1'b0;
	int unsigned r_delay = 0;
	int unsigned b_delay = 0;
	int w_index = 0;
	step_t steps [$];

	lsu_top u_dut (
		.clock(clock),
		.reset(reset),
		.req(req),
		.op(op),
		.addr(addr),
		.store_data(store_data),
		.busy(busy),
		.done(done),
		.load_data(load_data),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(bus_wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// ----------------------------------------------------------------------
	// checks and reference rules
	// ----------------------------------------------------------------------

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, actual,
				expected);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout: %s never happened", what);
		$display("Verification failed");
		$fatal(1, "stopped on timeout");
	endtask

	function automatic int access_bytes(input lsu_pkg::mem_op_t o);
		if (o == lsu_pkg::OP_LB || o == lsu_pkg::OP_LBU || o == lsu_pkg::OP_SB) begin
			return 1;
		end
		if (o == lsu_pkg::OP_LH || o == lsu_pkg::OP_LHU || o == lsu_pkg::OP_SH) begin
			return 2;
		end
		return 4;
	endfunction

	function automatic logic is_store(input lsu_pkg::mem_op_t o);
		return o == lsu_pkg::OP_SB || o == lsu_pkg::OP_SH || o == lsu_pkg::OP_SW;
	endfunction

	// bytes in the address's own word go first, the rest go second
	function automatic lsu_pkg::strb_t expected_strb(input lsu_pkg::mem_op_t o,
		input lsu_pkg::addr_t a, input logic second);
		lsu_pkg::strb_t s;
		lsu_pkg::addr_t b;
		s = '0;
		for (int k = 0; k < access_bytes(o); k++) begin
			b = a + 32'(k);
			if ((b[31:2] != a[31:2]) == second) begin
				s[b[2:0]] = 1'b1;
			end
		end
		return s;
	endfunction

	task automatic check_address(input lsu_pkg::addr_t seen, input int index);
		lsu_pkg::addr_t want;
		want = (index == 0) ? cur_addr : ((cur_addr & 32'hffff_fffc) + 32'd4);
		check_value(seen, want, "transfer address");
	endtask

	task automatic check_write(input lsu_pkg::strb_t strb, input lsu_pkg::beat_t beat,
		input int index);
		int k;
		check_value(32'(strb), 32'(expected_strb(cur_op, cur_addr, index != 0)), "wstrb");
		for (int p = 0; p < 8; p++) begin
			if (strb[p]) begin
				k = (p - int'(cur_addr[2:0]) + 8) % 8;
				check_value(32'(beat[8*p +: 8]), 32'(8'(cur_data >> (8*k))), "wdata byte");
			end
		end
	endtask

	function automatic lsu_pkg::beat_t read_beat(input logic [4:0] block);
		lsu_pkg::beat_t beat;
		for (int p = 0; p < 8; p++) begin
			beat[8*p +: 8] = mem[{block, 3'(p)}];
		end
		return beat;
	endfunction

	// ----------------------------------------------------------------------
	// bus memory responder
	// ----------------------------------------------------------------------

	always @(posedge clock) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			r_pending <= 1'b0;
		end else begin
			arready <= ($urandom % 3) != 0;
			if (arvalid && arready) begin
				check_address(araddr, ar_count - ar_mark);
				ar_count <= ar_count + 1;
				r_block <= araddr[7:3];
				r_pending <= 1'b1;
				r_delay <= $urandom % 4;
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
			if (r_pending) begin
				if (r_delay == 0) begin
					rvalid <= 1'b1;
					rdata <= read_beat(r_block);
					r_pending <= 1'b0;
				end else begin
					r_delay <= r_delay - 1;
				end
			end
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			b_pending <= 1'b0;
			// pattern over the whole byte address
			for (int i = 0; i < 256; i++) begin
				mem[i] <= 8'(i * 37 + 11);
			end
		end else begin
			awready <= ($urandom % 3) != 0;
			wready <= ($urandom % 3) != 0;
			if (awvalid && awready) begin
				check_address(awaddr, aw_count - aw_mark);
				w_index <= aw_count - aw_mark;
				aw_count <= aw_count + 1;
				w_block <= awaddr[7:3];
			end
			if (wvalid && wready) begin
				check_write(wstrb, bus_wdata, w_index);
				for (int p = 0; p < 8; p++) begin
					if (wstrb[p]) begin
						mem[{w_block, 3'(p)}] <= bus_wdata[8*p +: 8];
					end
				end
				b_pending <= 1'b1;
				b_delay <= $urandom % 4;
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (b_pending) begin
				if (b_delay == 0) begin
					bvalid <= 1'b1;
					b_pending <= 1'b0;
				end else begin
					b_delay <= b_delay - 1;
				end
			end
		end
	end

	always @(posedge clock) begin
		if (done) begin
			done_count <= done_count + 1;
		end
	end

	// ----------------------------------------------------------------------
	// request driving
	// ----------------------------------------------------------------------

	task automatic add_step(input lsu_pkg::mem_op_t o, input lsu_pkg::addr_t a,
		input lsu_pkg::word_t d, input lsu_pkg::word_t e, input logic [1:0] n);
		step_t s;
		s.op = o;
		s.addr = a;
		s.data = d;
		s.expected = e;
		s.xfers = n;
		steps.push_back(s);
	endtask

	task automatic issue_request(input lsu_pkg::mem_op_t o, input lsu_pkg::addr_t a,
		input lsu_pkg::word_t d);
		cur_op = o;
		cur_addr = a;
		cur_data = d;
		ar_mark = ar_count;
		aw_mark = aw_count;
		@(posedge clock);
		req <= 1'b1;
		op <= o;
		addr <= a;
		store_data <= d;
		@(posedge clock);
		req <= 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		@(posedge clock);
		while (!done) begin
			if (cycles >= DONE_TIMEOUT) begin
				timeout_fail("done pulse");
			end else begin
				cycles++;
				@(posedge clock);
			end
		end
	endtask

	task automatic wait_busy();
		int cycles;
		cycles = 0;
		@(posedge clock);
		while (!busy) begin
			if (cycles >= BUSY_TIMEOUT) begin
				timeout_fail("busy after request");
			end else begin
				cycles++;
				@(posedge clock);
			end
		end
	endtask

	task automatic run_step(input step_t s);
		issue_request(s.op, s.addr, s.data);
		wait_done();
		check_value(32'(ar_count + aw_count - ar_mark - aw_mark), 32'(s.xfers), "transfers");
		if (!is_store(s.op)) begin
			check_value(load_data, s.expected, "load data");
		end
	endtask

	// second request lands while the first is still busy
	task automatic check_ignored_request();
		logic [7:0] saved [4];
		int done_base;
		for (int i = 0; i < 4; i++) begin
			saved[i] = mem[8'h60 + 8'(i)];
		end
		done_base = done_count;
		issue_request(lsu_pkg::OP_LW, 32'h0000_0010, 32'h0);
		wait_busy();
		req <= 1'b1;
		op <= lsu_pkg::OP_SW;
		addr <= 32'h0000_0060;
		store_data <= 32'h5555_5555;
		@(posedge clock);
		req <= 1'b0;
		wait_done();
		check_value(load_data, 32'haabb_cc44, "load data with ignored req");
		repeat (20) @(posedge clock);
		check_value(32'(done_count - done_base), 32'd1, "done pulses");
		check_value(32'(ar_count + aw_count - ar_mark - aw_mark), 32'd1, "transfers");
		for (int i = 0; i < 4; i++) begin
			check_value(32'(mem[8'h60 + 8'(i)]), 32'(saved[i]), "memory after ignored req");
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------

	initial begin : main_seq
		int seed;
		seed = $urandom(32'h0692_c7ac);

		// op, address, store data, expected load, transfers
		add_step(lsu_pkg::OP_SW, 32'h0000_0010, 32'h1122_3344, 32'h0000_0000, 2'd1);
		add_step(lsu_pkg::OP_SH, 32'h0000_0012, 32'h0000_aabb, 32'h0000_0000, 2'd1);
		add_step(lsu_pkg::OP_SB, 32'h0000_0011, 32'h0000_00cc, 32'h0000_0000, 2'd1);
		add_step(lsu_pkg::OP_LW, 32'h0000_0010, 32'h0000_0000, 32'haabb_cc44, 2'd1);
		add_step(lsu_pkg::OP_SW, 32'h0000_0021, 32'hdead_beef, 32'h0000_0000, 2'd2);
		add_step(lsu_pkg::OP_LW, 32'h0000_0021, 32'h0000_0000, 32'hdead_beef, 2'd2);
		add_step(lsu_pkg::OP_SW, 32'h0000_002e, 32'h0102_0304, 32'h0000_0000, 2'd2);
		add_step(lsu_pkg::OP_LW, 32'h0000_002e, 32'h0000_0000, 32'h0102_0304, 2'd2);
		add_step(lsu_pkg::OP_SW, 32'h0000_0037, 32'hcafe_f00d, 32'h0000_0000, 2'd2);
		add_step(lsu_pkg::OP_LW, 32'h0000_0037, 32'h0000_0000, 32'hcafe_f00d, 2'd2);
		add_step(lsu_pkg::OP_SH, 32'h0000_0043, 32'h0000_8e7f, 32'h0000_0000, 2'd2);
		add_step(lsu_pkg::OP_LH, 32'h0000_0043, 32'h0000_0000, 32'hffff_8e7f, 2'd2);
		add_step(lsu_pkg::OP_LHU, 32'h0000_0043, 32'h0000_0000, 32'h0000_8e7f, 2'd2);
		add_step(lsu_pkg::OP_SB, 32'h0000_0050, 32'h0000_0085, 32'h0000_0000, 2'd1);
		add_step(lsu_pkg::OP_LB, 32'h0000_0050, 32'h0000_0000, 32'hffff_ff85, 2'd1);
		add_step(lsu_pkg::OP_LBU, 32'h0000_0050, 32'h0000_0000, 32'h0000_0085, 2'd1);
		add_step(lsu_pkg::OP_SH, 32'h0000_0056, 32'h0000_f123, 32'h0000_0000, 2'd1);
		add_step(lsu_pkg::OP_LH, 32'h0000_0056, 32'h0000_0000, 32'hffff_f123, 2'd1);
		add_step(lsu_pkg::OP_LHU, 32'h0000_0056, 32'h0000_0000, 32'h0000_f123, 2'd1);
		add_step(lsu_pkg::OP_LB, 32'h0000_0057, 32'h0000_0000, 32'hffff_fff1, 2'd1);

		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		check_value(32'({busy, done, arvalid, awvalid, wvalid, rready, bready}), 32'd0,
			"control outputs after reset");

		foreach (steps[i]) begin
			run_step(steps[i]);
			repeat (2) @(posedge clock);
		end

		check_ignored_request();

		$display("Verification passed");
		$finish;
	end

endmodule

/* flist.f */
verilog/lsu_pkg.sv
verilog/lsu_plan_if.sv
verilog/lsu_access_plan.sv
verilog/lsu_bus_seq.sv
verilog/lsu_byte_lane.sv
verilog/lsu_load_format.sv
verilog/lsu_top.sv
dv/lsu_tb.sv

/* run.sh */
#!/bin/sh
# build the LSU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module lsu_tb -f flist.f -o lsu_sim

# exit status of the simulation decides pass or fail
./obj_dir/lsu_sim

/* verilog/lsu_access_plan.sv */
`timescale 1ns/1ns

module lsu_access_plan (
	input logic clock,
	input logic reset,
	input logic req,
	input lsu_pkg::mem_op_t op,
	input lsu_pkg::addr_t addr,
	input lsu_pkg::word_t wdata,
	input logic busy,
	output logic start,
	lsu_plan_if.planner plan
);

	lsu_pkg::mem_op_t op_r;
	lsu_pkg::addr_t addr_r;
	lsu_pkg::word_t wdata_r;

	logic take;
	// access bytes relative to the aligned word
	logic [3:0] size_mask;
	// low nibble in this word, high nibble spills into the next word
	logic [7:0] spread;

	// byte k of the store data lands on beat byte (offset + k) mod 8
	function automatic lsu_pkg::beat_t place_bytes(
		input lsu_pkg::word_t data,
		input logic [2:0] offset
	);
		lsu_pkg::beat_t base;
		lsu_pkg::beat_t beat;
		logic [2:0] pos;
		base = {32'b0, data};
		beat = '0;
		for (int k = 0; k < lsu_pkg::BEAT_BYTES; k++) begin
			pos = offset + 3'(k);
			beat[8*pos +: 8] = base[8*k +: 8];
		end
		return beat;
	endfunction

	// ----------------------------------------------------------------------
	// request capture
	// ----------------------------------------------------------------------

	assign take = req && !busy;

	always_ff @(posedge clock) begin
		if (reset) begin
			start <= 1'b0;
		end else begin
			start <= take;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			op_r <= op;
			addr_r <= addr;
			wdata_r <= wdata;
		end
	end

	// ----------------------------------------------------------------------
	// transfer planning
	// ----------------------------------------------------------------------

	always_comb begin
		case (op_r[2:1])
			lsu_pkg::SIZE_BYTE: size_mask = 4'b0001;
			lsu_pkg::SIZE_HALF: size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	assign spread = {4'b0000, size_mask} << addr_r[1:0];

	assign plan.op = op_r;
	assign plan.offset = addr_r[2:0];
	assign plan.first_addr = addr_r;
	assign plan.second_addr = {addr_r[31:2], 2'b00} + 32'd4;

	// any byte past the word boundary forces a second transfer
	assign plan.need_second = |spread[7:4];

	// upper word of the beat when address bit 2 is set
	assign plan.first_strb = addr_r[2] ? {spread[3:0], 4'b0000} : {4'b0000, spread[3:0]};

	// next word is the upper half of this beat or the lower half of the next
	assign plan.second_strb = addr_r[2] ? {4'b0000, spread[7:4]} : {spread[7:4], 4'b0000};

	assign plan.wdata = place_bytes(wdata_r, addr_r[2:0]);

endmodule

/* verilog/lsu_bus_seq.sv */
`timescale 1ns/1ns

module lsu_bus_seq (
	input logic clock,
	input logic reset,
	lsu_plan_if.bus plan,
	input logic start,
	output logic arvalid,
	input logic arready,
	output lsu_pkg::addr_t araddr,
	input logic rvalid,
	output logic rready,
	output logic awvalid,
	input logic awready,
	output lsu_pkg::addr_t awaddr,
	output logic wvalid,
	input logic wready,
	output lsu_pkg::beat_t wdata,
	output lsu_pkg::strb_t wstrb,
	input logic bvalid,
	output logic bready,
	output logic busy,
	output logic first_beat,
	output logic final_beat,
	output logic store_done
);

	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR,
		R_DATA,
		R_SECOND_ADDR
	} rd_state_t;

	typedef enum logic [2:0] {
		W_IDLE,
		W_AW,
		W_W,
		W_B,
		W_SECOND_AW
	} wr_state_t;

	rd_state_t r_state;
	wr_state_t w_state;

	logic is_store;
	logic last_transfer;
	// high while the second transfer of a split access runs
	logic second;
	// covers the done cycle after the last handshake
	logic done_slot;
	logic r_shake;
	logic b_shake;

	assign is_store = plan.op[3];
	assign last_transfer = !plan.need_second || second;
	assign r_shake = (r_state == R_DATA) && rvalid;
	assign b_shake = (w_state == W_B) && bvalid;

	// ----------------------------------------------------------------------
	// read machine
	// ----------------------------------------------------------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			r_state <= R_IDLE;
		end else begin
			case (r_state)
				R_IDLE: begin
					if (start && !is_store) begin
						r_state <= arready ? R_DATA : R_ADDR;
					end
				end
				R_ADDR, R_SECOND_ADDR: begin
					if (arready) begin
						r_state <= R_DATA;
					end
				end
				R_DATA: begin
					if (rvalid) begin
						r_state <= last_transfer ? R_IDLE : R_SECOND_ADDR;
					end
				end
				default: r_state <= R_IDLE;
			endcase
		end
	end

	// address is offered in the start cycle itself
	assign arvalid = (r_state == R_IDLE && start && !is_store)
		|| r_state == R_ADDR || r_state == R_SECOND_ADDR;
	assign rready = (r_state == R_DATA);
	assign araddr = second ? plan.second_addr : plan.first_addr;

	assign first_beat = r_shake && !last_transfer;
	assign final_beat = r_shake && last_transfer;

	// ----------------------------------------------------------------------
	// write machine
	// ----------------------------------------------------------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			w_state <= W_IDLE;
		end else begin
			case (w_state)
				W_IDLE: begin
					if (start && is_store) begin
						w_state <= awready ? W_W : W_AW;
					end
				end
				W_AW, W_SECOND_AW: begin
					if (awready) begin
						w_state <= W_W;
					end
				end
				W_W: begin
					if (wready) begin
						w_state <= W_B;
					end
				end
				W_B: begin
					if (bvalid) begin
						w_state <= last_transfer ? W_IDLE : W_SECOND_AW;
					end
				end
				default: w_state <= W_IDLE;
			endcase
		end
	end

	assign awvalid = (w_state == W_IDLE && start && is_store)
		|| w_state == W_AW || w_state == W_SECOND_AW;
	assign wvalid = (w_state == W_W);
	assign bready = (w_state == W_B);
	assign awaddr = second ? plan.second_addr : plan.first_addr;
	assign wstrb = second ? plan.second_strb : plan.first_strb;
	// same beat on both transfers and the strobes pick the bytes
	assign wdata = plan.wdata;

	assign store_done = b_shake && last_transfer;

	// ----------------------------------------------------------------------
	// shared transfer flag and busy
	// ----------------------------------------------------------------------

	// set after the first handshake of a split access and cleared after the last
	always_ff @(posedge clock) begin
		if (reset) begin
			second <= 1'b0;
			done_slot <= 1'b0;
		end else begin
			if (r_shake || b_shake) begin
				second <= !last_transfer;
			end
			done_slot <= final_beat || store_done;
		end
	end

	assign busy = start || r_state != R_IDLE || w_state != W_IDLE || done_slot;

endmodule

/* verilog/lsu_byte_lane.sv */
`timescale 1ns/1ns

module lsu_byte_lane #(
	parameter int LANE = 0
) (
	input logic clock,
	input logic reset,
	lsu_plan_if.lane plan,
	input lsu_pkg::beat_t rdata,
	input logic first_beat,
	output lsu_pkg::byte_t lane_byte
);

	localparam int HIGH = LANE + lsu_pkg::BEAT_BYTES / 2;

	lsu_pkg::byte_t from_first;
	lsu_pkg::byte_t from_second;
	lsu_pkg::byte_t held;

	// at most one of the two beat positions is strobed per transfer
	assign from_first = ({8{plan.first_strb[LANE]}} & rdata[8*LANE +: 8])
		| ({8{plan.first_strb[HIGH]}} & rdata[8*HIGH +: 8]);
	assign from_second = ({8{plan.second_strb[LANE]}} & rdata[8*LANE +: 8])
		| ({8{plan.second_strb[HIGH]}} & rdata[8*HIGH +: 8]);

	always_ff @(posedge clock) begin
		if (reset) begin
			held <= '0;
		end else if (first_beat) begin
			held <= from_first;
		end
	end

	// split load: held byte or live second beat, zero where not strobed
	assign lane_byte = plan.need_second ? (held | from_second) : from_first;

endmodule

/* verilog/lsu_load_format.sv */
`timescale 1ns/1ns

module lsu_load_format (
	input logic clock,
	input logic reset,
	lsu_plan_if.load plan,
	input lsu_pkg::byte_t lane_bytes [4],
	input logic final_beat,
	input logic store_done,
	output logic done,
	output lsu_pkg::word_t load_data
);

	lsu_pkg::word_t gathered;
	lsu_pkg::word_t rotated;
	lsu_pkg::word_t formatted;
	logic [63:0] doubled;

	assign gathered = {lane_bytes[3], lane_bytes[2], lane_bytes[1], lane_bytes[0]};

	// bring the lane of access byte 0 down to bits 7:0
	assign doubled = {gathered, gathered} >> (8 * plan.offset[1:0]);
	assign rotated = doubled[31:0];

	always_comb begin
		case (plan.op[2:1])
			lsu_pkg::SIZE_BYTE: begin
				formatted = plan.op[0] ? {24'b0, rotated[7:0]}
					: {{24{rotated[7]}}, rotated[7:0]};
			end
			lsu_pkg::SIZE_HALF: begin
				formatted = plan.op[0] ? {16'b0, rotated[15:0]}
					: {{16{rotated[15]}}, rotated[15:0]};
			end
			default: formatted = rotated;
		endcase
	end

	always_ff @(posedge clock) begin
		if (final_beat) begin
			load_data <= formatted;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= final_beat || store_done;
		end
	end

endmodule

/* verilog/lsu_pkg.sv */
package lsu_pkg;

	// ----------------------------------------------------------------------
	// bus and ISA widths
	// ----------------------------------------------------------------------

	localparam int BEAT_BYTES = 8;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [8*BEAT_BYTES-1:0] beat_t;
	typedef logic [BEAT_BYTES-1:0] strb_t;
	typedef logic [7:0] byte_t;

	// ----------------------------------------------------------------------
	// operation codes
	// ----------------------------------------------------------------------

	// bit 3 store, bits 2:1 size, bit 0 unsigned
	typedef logic [3:0] mem_op_t;

	// size field values
	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;

	// loads
	localparam mem_op_t OP_LB = 4'b0000;
	localparam mem_op_t OP_LBU = 4'b0001;
	localparam mem_op_t OP_LH = 4'b0010;
	localparam mem_op_t OP_LHU = 4'b0011;
	localparam mem_op_t OP_LW = 4'b0100;

	// stores
	localparam mem_op_t OP_SB = 4'b1000;
	localparam mem_op_t OP_SH = 4'b1010;
	localparam mem_op_t OP_SW = 4'b1100;

endpackage

/* verilog/lsu_plan_if.sv */
`timescale 1ns/1ns

// planned access, stable from capture until done
interface lsu_plan_if;

	lsu_pkg::mem_op_t op;
	lsu_pkg::addr_t first_addr;
	lsu_pkg::addr_t second_addr;
	lsu_pkg::strb_t first_strb;
	lsu_pkg::strb_t second_strb;
	logic need_second;
	lsu_pkg::beat_t wdata;
	// low address bits, byte position inside the beat
	logic [2:0] offset;

	modport planner (
		output op, first_addr, second_addr, first_strb, second_strb,
		output need_second, wdata, offset
	);

	modport bus (
		input op, first_addr, second_addr, first_strb, second_strb,
		input need_second, wdata
	);

	modport lane (input first_strb, second_strb, need_second);

	modport load (input op, offset);

endinterface

/* verilog/lsu_top.sv */
`timescale 1ns/1ns

module lsu_top (
	input logic clock,
	input logic reset,
	// request and result
	input logic req,
	input lsu_pkg::mem_op_t op,
	input lsu_pkg::addr_t addr,
	input lsu_pkg::word_t store_data,
	output logic busy,
	output logic done,
	output lsu_pkg::word_t load_data,
	// read channels
	output logic arvalid,
	input logic arready,
	output lsu_pkg::addr_t araddr,
	input logic rvalid,
	output logic rready,
	input lsu_pkg::beat_t rdata,
	// write channels
	output logic awvalid,
	input logic awready,
	output lsu_pkg::addr_t awaddr,
	output logic wvalid,
	input logic wready,
	output lsu_pkg::beat_t wdata,
	output lsu_pkg::strb_t wstrb,
	input logic bvalid,
	output logic bready
);

	logic start;
	logic first_beat;
	logic final_beat;
	logic store_done;
	lsu_pkg::byte_t lane_bytes [4];

	lsu_plan_if plan ();

	lsu_access_plan u_plan (
		.clock(clock),
		.reset(reset),
		.req(req),
		.op(op),
		.addr(addr),
		.wdata(store_data),
		.busy(busy),
		.start(start),
		.plan(plan.planner)
	);

	lsu_bus_seq u_seq (
		.clock(clock),
		.reset(reset),
		.plan(plan.bus),
		.start(start),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.busy(busy),
		.first_beat(first_beat),
		.final_beat(final_beat),
		.store_done(store_done)
	);

	// one lane per byte of the loaded word
	for (genvar i = 0; i < 4; i++) begin : g_lane
		localparam int LANE = i;

		lsu_byte_lane #(.LANE(LANE)) u_lane (
			.clock(clock),
			.reset(reset),
			.plan(plan.lane),
			.rdata(rdata),
			.first_beat(first_beat),
			.lane_byte(lane_bytes[i])
		);
	end

	lsu_load_format u_format (
		.clock(clock),
		.reset(reset),
		.plan(plan.load),
		.lane_bytes(lane_bytes),
		.final_beat(final_beat),
		.store_done(store_done),
		.done(done),
		.load_data(load_data)
	);

endmodule
